/* src/capture_pkg.sv */
`default_nettype none

package capture_pkg;

    // bus and buffer widths
    localparam int AXI_ADDR_WIDTH = 16;
    localparam int AXI_DATA_WIDTH = 32;
    localparam int SIZE_WIDTH = 11;   // crop sizes and pixel counters
    localparam int COUNT_WIDTH = 16;  // captured byte count

    // ********************
    // register map
    // ********************
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_CONTROL = 16'h0000;     // bit 0 starts a capture
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_FRAME_SIZE = 16'h0004;  // y in 26:16, x in 10:0
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_STATUS = 16'h0008;
    localparam logic [AXI_ADDR_WIDTH-1:0] REG_BYTE_COUNT = 16'h000C;
    localparam logic [AXI_ADDR_WIDTH-1:0] BUFFER_BASE = 16'h8000;     // image buffer window

    // status register bits
    localparam int STATUS_ARMED_BIT = 0;
    localparam int STATUS_BUSY_BIT = 1;
    localparam int STATUS_DONE_BIT = 2;
    localparam int STATUS_OVERFLOW_BIT = 3;

endpackage

`default_nettype wire

/* src/image_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module image_buffer #(
    parameter int BUFFER_WORDS = 1024
) (
    input wire logic clock_in,

    input wire logic write_enable,
    input wire logic [$clog2(BUFFER_WORDS)-1:0] write_address,
    input wire logic [capture_pkg::AXI_DATA_WIDTH-1:0] write_data,
    input wire logic [capture_pkg::AXI_DATA_WIDTH/8-1:0] write_strobe,

    input wire logic read_enable,
    input wire logic [$clog2(BUFFER_WORDS)-1:0] read_address,
    output logic [capture_pkg::AXI_DATA_WIDTH-1:0] read_data
);
    import capture_pkg::*;

    logic [AXI_DATA_WIDTH-1:0] memory [BUFFER_WORDS];

    // byte lanes written only where strobed
    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            for (int lane = 0; lane < AXI_DATA_WIDTH / 8; lane++) begin
                if (write_strobe[lane]) begin
                    memory[write_address][lane*8 +: 8] <= write_data[lane*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (read_enable) begin
            read_data <= memory[read_address];  // holds until the next read
        end
    end

endmodule

`default_nettype wire

/* src/frame_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_capture #(
    parameter int PIXEL_WIDTH = 10,
    parameter int BUFFER_WORDS = 1024
) (
    input wire logic clock_in,
    input wire logic reset_n_in,

    input wire logic [PIXEL_WIDTH-1:0] red_data,
    input wire logic [PIXEL_WIDTH-1:0] green_data,
    input wire logic [PIXEL_WIDTH-1:0] blue_data,
    input wire logic line_valid,
    input wire logic frame_valid,

    input wire logic start,
    input wire logic [capture_pkg::SIZE_WIDTH-1:0] x_size,
    input wire logic [capture_pkg::SIZE_WIDTH-1:0] y_size,

    output logic armed,
    output logic busy,
    output logic done,
    output logic overflow,
    output logic [capture_pkg::COUNT_WIDTH-1:0] byte_count,

    output logic write_enable,
    output logic [$clog2(BUFFER_WORDS)-1:0] write_address,
    output logic [capture_pkg::AXI_DATA_WIDTH-1:0] write_data,
    output logic [capture_pkg::AXI_DATA_WIDTH/8-1:0] write_strobe
);
    import capture_pkg::*;

    localparam int ADDR_BITS = $clog2(BUFFER_WORDS);
    localparam int LANES = AXI_DATA_WIDTH / 8;
    localparam int CAPACITY = BUFFER_WORDS * LANES;  // bytes

    logic frame_valid_q;
    logic line_valid_q;
    logic finishing;  // cycle between frame end and done
    logic [SIZE_WIDTH-1:0] column;
    logic [SIZE_WIDTH-1:0] row;
    logic [AXI_DATA_WIDTH-1:0] pack_data;
    logic [AXI_DATA_WIDTH-1:0] merged_data;
    logic [LANES-1:0] pack_strobe;
    logic [LANES-1:0] merged_strobe;
    logic [1:0] lane;
    logic [7:0] pixel_byte;
    logic frame_rise;
    logic frame_fall;
    logic line_fall;
    logic frame_begin;
    logic capturing;
    logic pixel_kept;
    logic store;
    logic word_full;
    logic flush;

    // ********************
    // edges and cropping
    // ********************
    assign frame_rise = frame_valid && !frame_valid_q;
    assign frame_fall = !frame_valid && frame_valid_q;
    assign line_fall = !line_valid && line_valid_q;

    assign frame_begin = armed && !busy && frame_rise;  // frame already running is skipped
    assign capturing = (busy && !finishing) || frame_begin;

    assign pixel_kept = capturing && frame_valid && line_valid
                        && column < x_size && row < y_size;
    assign store = pixel_kept && byte_count < CAPACITY;  // beyond capacity only flags overflow

    // rgb332, red in the top bits
    assign pixel_byte = {red_data[PIXEL_WIDTH-1 -: 3],
                         green_data[PIXEL_WIDTH-1 -: 3],
                         blue_data[PIXEL_WIDTH-1 -: 2]};

    // ********************
    // packing
    // ********************
    assign lane = byte_count[1:0];
    assign word_full = store && lane == 2'd3;
    assign flush = busy && !finishing && frame_fall && |pack_strobe;  // partial last word

    always_comb begin
        merged_data = pack_data;
        merged_strobe = pack_strobe;
        if (store) begin
            merged_data[lane*8 +: 8] = pixel_byte;
            merged_strobe[lane] = 1'b1;
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            frame_valid_q <= 1'b0;
            line_valid_q <= 1'b0;
            armed <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            overflow <= 1'b0;
            finishing <= 1'b0;
            byte_count <= '0;
            pack_strobe <= '0;
            write_enable <= 1'b0;
            column <= '0;
            row <= '0;
        end else begin
            frame_valid_q <= frame_valid;
            line_valid_q <= line_valid;
            write_enable <= word_full || flush;

            if (start && !armed) begin
                armed <= 1'b1;
                done <= 1'b0;
                overflow <= 1'b0;
                byte_count <= '0;
                pack_strobe <= '0;
            end

            if (frame_begin) begin
                busy <= 1'b1;
            end
            finishing <= busy && !finishing && frame_fall;
            if (finishing) begin  // last word has reached the buffer by now
                busy <= 1'b0;
                armed <= 1'b0;
                done <= 1'b1;
            end

            // column counts within a line, row counts line ends
            if (!line_valid) begin
                column <= '0;
            end else if (frame_valid && column < x_size) begin
                column <= column + 1'b1;
            end
            if (!busy) begin
                row <= '0;
            end else if (line_fall && row < y_size) begin
                row <= row + 1'b1;
            end

            if (store) begin
                byte_count <= byte_count + 1'b1;
            end
            if (pixel_kept && !store) begin
                overflow <= 1'b1;
            end

            if (word_full || flush) begin
                pack_strobe <= '0;
            end else if (store) begin
                pack_strobe <= merged_strobe;
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (store) begin
            pack_data <= merged_data;
        end
        if (word_full || flush) begin
            write_address <= byte_count[ADDR_BITS+1:2];  // word holding the current byte
            write_data <= merged_data;
            write_strobe <= merged_strobe;
        end
    end

endmodule

`default_nettype wire

/* src/capture_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_regs #(
    parameter int BUFFER_WORDS = 1024
) (
    input wire logic clock_in,
    input wire logic reset_n_in,

    input wire logic [capture_pkg::AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input wire logic s_axi_awvalid,
    output logic s_axi_awready,
    input wire logic [capture_pkg::AXI_DATA_WIDTH-1:0] s_axi_wdata,
    input wire logic [capture_pkg::AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
    input wire logic s_axi_wvalid,
    output logic s_axi_wready,
    output logic [1:0] s_axi_bresp,
    output logic s_axi_bvalid,
    input wire logic s_axi_bready,
    input wire logic [capture_pkg::AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input wire logic s_axi_arvalid,
    output logic s_axi_arready,
    output logic [capture_pkg::AXI_DATA_WIDTH-1:0] s_axi_rdata,
    output logic [1:0] s_axi_rresp,
    output logic s_axi_rvalid,
    input wire logic s_axi_rready,

    output logic start,
    output logic [capture_pkg::SIZE_WIDTH-1:0] x_size,
    output logic [capture_pkg::SIZE_WIDTH-1:0] y_size,

    input wire logic armed,
    input wire logic busy,
    input wire logic done,
    input wire logic overflow,
    input wire logic [capture_pkg::COUNT_WIDTH-1:0] byte_count,

    output logic read_enable,
    output logic [$clog2(BUFFER_WORDS)-1:0] read_address,
    input wire logic [capture_pkg::AXI_DATA_WIDTH-1:0] read_data
);
    import capture_pkg::*;

    localparam int ADDR_BITS = $clog2(BUFFER_WORDS);
    localparam int BUFFER_END = BUFFER_BASE + BUFFER_WORDS * (AXI_DATA_WIDTH / 8);

    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_SIZE,
        TGT_STATUS,
        TGT_COUNT,
        TGT_BUFFER
    } read_target_t;

    logic write_fire;
    logic read_fire;
    logic in_window;
    logic read_stage;  // target registered, data arriving
    read_target_t read_target;
    read_target_t read_target_next;
    logic [AXI_DATA_WIDTH-1:0] read_value;

    assign s_axi_bresp = 2'b00;  // always OKAY
    assign s_axi_rresp = 2'b00;

    // ********************
    // write channel
    // ********************
    assign write_fire = s_axi_awready && s_axi_awvalid && s_axi_wready && s_axi_wvalid;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            s_axi_awready <= 1'b0;
            s_axi_wready <= 1'b0;
            s_axi_bvalid <= 1'b0;
            start <= 1'b0;
            x_size <= '0;
            y_size <= '0;
        end else begin
            // address and data taken together, one at a time
            s_axi_awready <= s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
            s_axi_wready <= s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;

            if (write_fire) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end

            start <= write_fire && s_axi_awaddr == REG_CONTROL && s_axi_wdata[0];

            if (write_fire && s_axi_awaddr == REG_FRAME_SIZE) begin
                if (s_axi_wstrb[0]) x_size[7:0] <= s_axi_wdata[7:0];
                if (s_axi_wstrb[1]) x_size[SIZE_WIDTH-1:8] <= s_axi_wdata[SIZE_WIDTH-1:8];
                if (s_axi_wstrb[2]) y_size[7:0] <= s_axi_wdata[23:16];
                if (s_axi_wstrb[3]) y_size[SIZE_WIDTH-1:8] <= s_axi_wdata[SIZE_WIDTH+15:24];
            end
        end
    end

    // ********************
    // read channel
    // ********************
    assign read_fire = s_axi_arready && s_axi_arvalid;
    assign in_window = s_axi_araddr >= BUFFER_BASE && s_axi_araddr < BUFFER_END;

    // buffer read issued on the accepting edge
    assign read_enable = read_fire && in_window;
    assign read_address = s_axi_araddr[ADDR_BITS+1:2];

    always_comb begin
        read_target_next = TGT_NONE;  // control and unmapped read 0
        if (in_window) begin
            read_target_next = TGT_BUFFER;
        end else begin
            case (s_axi_araddr)
                REG_FRAME_SIZE: read_target_next = TGT_SIZE;
                REG_STATUS: read_target_next = TGT_STATUS;
                REG_BYTE_COUNT: read_target_next = TGT_COUNT;
                default: read_target_next = TGT_NONE;
            endcase
        end
    end

    always_comb begin
        read_value = '0;
        case (read_target)
            TGT_SIZE: begin
                read_value[SIZE_WIDTH-1:0] = x_size;
                read_value[16 +: SIZE_WIDTH] = y_size;
            end
            TGT_STATUS: begin
                read_value[STATUS_ARMED_BIT] = armed;
                read_value[STATUS_BUSY_BIT] = busy;
                read_value[STATUS_DONE_BIT] = done;
                read_value[STATUS_OVERFLOW_BIT] = overflow;
            end
            TGT_COUNT: read_value[COUNT_WIDTH-1:0] = byte_count;
            TGT_BUFFER: read_value = read_data;
            default: read_value = '0;
        endcase
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            s_axi_arready <= 1'b0;
            read_stage <= 1'b0;
            s_axi_rvalid <= 1'b0;
        end else begin
            s_axi_arready <= s_axi_arvalid && !s_axi_arready && !read_stage && !s_axi_rvalid;
            read_stage <= read_fire;
            if (read_stage) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (read_fire) begin
            read_target <= read_target_next;
        end
        if (read_stage) begin
            s_axi_rdata <= read_value;  // held until rready
        end
    end

endmodule

`default_nettype wire

/* src/capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_top #(
    parameter int BUFFER_WORDS = 1024,
    parameter int PIXEL_WIDTH = 10
) (
    input wire logic clock_in,
    input wire logic reset_n_in,

    // pixel stream, never stalled
    input wire logic [PIXEL_WIDTH-1:0] red_data,
    input wire logic [PIXEL_WIDTH-1:0] green_data,
    input wire logic [PIXEL_WIDTH-1:0] blue_data,
    input wire logic line_valid,
    input wire logic frame_valid,

    // axi4-lite slave
    input wire logic [capture_pkg::AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input wire logic s_axi_awvalid,
    output logic s_axi_awready,
    input wire logic [capture_pkg::AXI_DATA_WIDTH-1:0] s_axi_wdata,
    input wire logic [capture_pkg::AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
    input wire logic s_axi_wvalid,
    output logic s_axi_wready,
    output logic [1:0] s_axi_bresp,
    output logic s_axi_bvalid,
    input wire logic s_axi_bready,
    input wire logic [capture_pkg::AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input wire logic s_axi_arvalid,
    output logic s_axi_arready,
    output logic [capture_pkg::AXI_DATA_WIDTH-1:0] s_axi_rdata,
    output logic [1:0] s_axi_rresp,
    output logic s_axi_rvalid,
    input wire logic s_axi_rready
);
    import capture_pkg::*;

    localparam int ADDR_BITS = $clog2(BUFFER_WORDS);

    // registers to capture
    logic start;
    logic [SIZE_WIDTH-1:0] x_size;
    logic [SIZE_WIDTH-1:0] y_size;

    // capture status back to registers
    logic armed;
    logic busy;
    logic done;
    logic overflow;
    logic [COUNT_WIDTH-1:0] byte_count;

    // buffer ports
    logic write_enable;
    logic [ADDR_BITS-1:0] write_address;
    logic [AXI_DATA_WIDTH-1:0] write_data;
    logic [AXI_DATA_WIDTH/8-1:0] write_strobe;
    logic read_enable;
    logic [ADDR_BITS-1:0] read_address;
    logic [AXI_DATA_WIDTH-1:0] read_data;

    capture_regs #(
        .BUFFER_WORDS(BUFFER_WORDS)
    ) u_regs (.*);

    frame_capture #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .BUFFER_WORDS(BUFFER_WORDS)
    ) u_capture (.*);

    image_buffer #(
        .BUFFER_WORDS(BUFFER_WORDS)
    ) u_buffer (.*);

endmodule

`default_nettype wire

/* dv/capture_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_tb;
    import capture_pkg::*;

    localparam int CAPACITY = 64;        // 16 buffer words
    localparam int CYCLE_LIMIT = 20000;  // all tests need a few thousand cycles

    logic clock_in = 1'b0;
    logic reset_n_in = 1'b0;
    logic [9:0] red_data = '0;
    logic [9:0] green_data = '0;
    logic [9:0] blue_data = '0;
    logic line_valid = 1'b0;
    logic frame_valid = 1'b0;
    logic [AXI_ADDR_WIDTH-1:0] s_axi_awaddr = '0;
    logic [AXI_ADDR_WIDTH-1:0] s_axi_araddr = '0;
    logic [AXI_DATA_WIDTH-1:0] s_axi_wdata = '0;
    logic [3:0] s_axi_wstrb = 4'hF;
    logic s_axi_awvalid = 1'b0;
    logic s_axi_wvalid = 1'b0;
    logic s_axi_bready = 1'b0;
    logic s_axi_arvalid = 1'b0;
    logic s_axi_rready = 1'b0;
    logic s_axi_awready;
    logic s_axi_wready;
    logic s_axi_bvalid;
    logic s_axi_arready;
    logic s_axi_rvalid;
    logic [1:0] s_axi_bresp;
    logic [1:0] s_axi_rresp;
    logic [AXI_DATA_WIDTH-1:0] s_axi_rdata;

    integer seed = 55;
    int cycle_count = 0;
    int error_count = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic [7:0] pixel_byte [8][12];  // rgb332 of the last frame driven
    int frame_cols;
    int frame_lines;
    logic [7:0] exp_bytes [CAPACITY];
    int exp_count;
    logic exp_overflow;

    capture_top #(.BUFFER_WORDS(16), .PIXEL_WIDTH(10)) u_dut (.*);

    always #20 clock_in = ~clock_in;

    always @(posedge clock_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic int rand_range(input int low, input int high);
        rand_range = low + int'($unsigned($random(seed)) % (high - low + 1));
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] expected, input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    // ********************
    // axi4-lite master
    // ********************
    task automatic write_reg(input logic [15:0] address, input logic [31:0] data);
        @(posedge clock_in);
        s_axi_awaddr <= address;
        s_axi_wdata <= data;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid <= 1'b1;
        @(negedge clock_in);
        while (!s_axi_awready) @(negedge clock_in);
        compare(s_axi_wready, 1'b1, "wready alongside awready");
        @(posedge clock_in);  // address and data taken here
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid <= 1'b0;
        s_axi_bready <= 1'b1;
        @(negedge clock_in);
        while (!s_axi_bvalid) @(negedge clock_in);
        compare(s_axi_bresp, 2'b00, "write response");
        @(posedge clock_in);
        s_axi_bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] address, output logic [31:0] data);
        @(posedge clock_in);
        s_axi_araddr <= address;
        s_axi_arvalid <= 1'b1;
        @(negedge clock_in);
        while (!s_axi_arready) @(negedge clock_in);
        @(posedge clock_in);
        s_axi_arvalid <= 1'b0;
        s_axi_rready <= 1'b1;
        @(negedge clock_in);
        while (!s_axi_rvalid) @(negedge clock_in);
        data = s_axi_rdata;
        compare(s_axi_rresp, 2'b00, "read response");
        @(posedge clock_in);
        s_axi_rready <= 1'b0;
    endtask

    // ********************
    // pixel side
    // ********************
    task automatic drive_sample(input logic fv, input logic lv, input int row, input int col);
        logic [31:0] r;
        logic [31:0] g;
        logic [31:0] b;
        r = $random(seed);
        g = $random(seed);
        b = $random(seed);
        if (lv) begin
            pixel_byte[row][col] = {r[9:7], g[9:7], b[9:8]};
        end
        @(posedge clock_in);
        frame_valid <= fv;
        line_valid <= lv;
        red_data <= r[9:0];  // noise outside valid samples too
        green_data <= g[9:0];
        blue_data <= b[9:0];
    endtask

    task automatic drive_frame(input int cols, input int lines);
        frame_cols = cols;
        frame_lines = lines;
        repeat (rand_range(1, 3)) drive_sample(1'b0, 1'b0, 0, 0);
        repeat (rand_range(1, 3)) drive_sample(1'b1, 1'b0, 0, 0);
        for (int row = 0; row < lines; row++) begin
            for (int col = 0; col < cols; col++) begin
                drive_sample(1'b1, 1'b1, row, col);
            end
            repeat (rand_range(1, 4)) drive_sample(1'b1, 1'b0, 0, 0);  // line blanking
        end
        repeat (rand_range(2, 4)) drive_sample(1'b0, 1'b0, 0, 0);
    endtask

    task automatic build_model(input int crop_x, input int crop_y);
        exp_count = 0;
        exp_overflow = 1'b0;
        for (int row = 0; row < frame_lines; row++) begin
            for (int col = 0; col < frame_cols; col++) begin
                if (col < crop_x && row < crop_y && exp_count < CAPACITY) begin
                    exp_bytes[exp_count] = pixel_byte[row][col];
                    exp_count++;
                end else if (col < crop_x && row < crop_y) begin
                    exp_overflow = 1'b1;  // kept but no room left
                end
            end
        end
    endtask

    task automatic pick_crop(input int cols, input int lines, output int crop_x,
                             output int crop_y);
        do begin
            crop_x = rand_range(1, 13);
            crop_y = rand_range(1, 9);
        end while ((crop_x < cols ? crop_x : cols) * (crop_y < lines ? crop_y : lines)
                   > CAPACITY);
    endtask

    task automatic arm(input int crop_x, input int crop_y);
        logic [31:0] data;
        write_reg(REG_FRAME_SIZE, {5'd0, crop_y[10:0], 5'd0, crop_x[10:0]});
        write_reg(REG_CONTROL, 32'h1);
        read_reg(REG_STATUS, data);
        compare(data, 32'h1, "status after start");
    endtask

    task automatic capture_and_check(input int cols, input int lines, input int crop_x,
                                     input int crop_y);
        logic [31:0] data;
        int polls;
        drive_frame(cols, lines);
        build_model(crop_x, crop_y);
        polls = 0;
        read_reg(REG_STATUS, data);
        while (!data[STATUS_DONE_BIT] && polls < 10) begin
            read_reg(REG_STATUS, data);
            polls++;
        end
        if (!data[STATUS_DONE_BIT]) begin
            $display("done was not set within 10 status reads after the frame ended");
            error_count++;
        end
        compare(data, {28'd0, exp_overflow, 3'b100}, "status after the frame");
        read_reg(REG_BYTE_COUNT, data);
        compare(data, exp_count, "byte count");
        for (int w = 0; w * 4 < exp_count; w++) begin
            read_reg(BUFFER_BASE | {w[13:0], 2'b00}, data);
            for (int lane = 0; lane < 4 && w * 4 + lane < exp_count; lane++) begin
                compare(data[lane*8 +: 8], exp_bytes[w*4 + lane],
                        $sformatf("buffer byte %0d", w * 4 + lane));
            end
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %0d, %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d, %s: %0d mismatches", tests_run, name,
                     error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] value;
        int cols;
        int lines;
        int crop_x;
        int crop_y;
        repeat (8) @(posedge clock_in);
        reset_n_in <= 1'b1;

        read_reg(REG_STATUS, data);
        compare(data, 32'h0, "status after reset");
        read_reg(REG_FRAME_SIZE, data);
        compare(data, 32'h0, "frame size after reset");
        read_reg(REG_BYTE_COUNT, data);
        compare(data, 32'h0, "byte count after reset");
        end_test("reset state");

        repeat (4) begin
            value = $random(seed);
            write_reg(REG_FRAME_SIZE, value);
            read_reg(REG_FRAME_SIZE, data);
            compare(data, value & 32'h07FF_07FF, "frame size readback");
        end
        write_reg(REG_STATUS, 32'hFFFF_FFFF);
        read_reg(REG_STATUS, data);
        compare(data, 32'h0, "status after a write to it");
        read_reg(16'h0040, data);
        compare(data, 32'h0, "unmapped register");
        end_test("register access");

        drive_frame(rand_range(2, 12), rand_range(2, 8));
        read_reg(REG_STATUS, data);
        compare(data, 32'h0, "status after an unarmed frame");
        read_reg(REG_BYTE_COUNT, data);
        compare(data, 32'h0, "byte count after an unarmed frame");
        end_test("idle frame ignored");

        repeat (6) begin
            cols = rand_range(2, 12);
            lines = rand_range(2, 8);
            pick_crop(cols, lines, crop_x, crop_y);
            arm(crop_x, crop_y);
            capture_and_check(cols, lines, crop_x, crop_y);
        end
        end_test("cropped capture");

        cols = rand_range(2, 12);
        lines = rand_range(2, 8);
        pick_crop(cols, lines, crop_x, crop_y);
        write_reg(REG_FRAME_SIZE, {5'd0, crop_y[10:0], 5'd0, crop_x[10:0]});
        fork
            drive_frame(12, 8);
            begin
                repeat (12) @(posedge clock_in);  // frame has risen by now
                write_reg(REG_CONTROL, 32'h1);
            end
        join
        read_reg(REG_STATUS, data);
        compare(data, 32'h1, "status after the skipped frame");
        capture_and_check(cols, lines, crop_x, crop_y);
        end_test("late arm");

        arm(12, 8);
        capture_and_check(12, 8, 12, 8);  // 96 pixels into 64 bytes
        write_reg(REG_CONTROL, 32'h1);
        read_reg(REG_STATUS, data);
        compare(data, 32'h1, "status after restart");
        read_reg(REG_BYTE_COUNT, data);
        compare(data, 32'h0, "byte count after restart");
        end_test("overflow");

        $display("%0d tests run, %0d with mismatches, %0d mismatches in all",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* capture_top.f */
src/capture_pkg.sv
src/image_buffer.sv
src/frame_capture.sv
src/capture_regs.sv
src/capture_top.sv
dv/capture_tb.sv
